// ==== tracker_settings.svh ====
`ifndef TRACKER_SETTINGS_SVH
`define TRACKER_SETTINGS_SVH

// camera coordinate widths
`define TRK_HCOUNT_W 11
`define TRK_VCOUNT_W 10

// width of the per-frame sums and of the divider
`define TRK_SUM_W 32

// pipeline depths, in clk_camera cycles
`define TRK_CHROMA_LAT 3
`define TRK_THRESH_LAT 1

// threshold window after reset, same for both targets
`define TRK_LOWER_RST 8'hA0
`define TRK_UPPER_RST 8'hF0

// apb register port
`define TRK_ADDR_W 4
`define TRK_DATA_W 32
`define TRK_REG_BOUNDS0 'h0
`define TRK_REG_BOUNDS1 'h4
`define TRK_REG_CENTRE0 'h8
`define TRK_REG_CENTRE1 'hC

`endif

// ==== tracker_pkg.sv ====
`include "tracker_settings.svh"

package tracker_pkg;

  // raw camera beat
  typedef struct packed {
    logic                     valid;
    logic                     sof;
    logic [`TRK_HCOUNT_W-1:0] hcount;
    logic [`TRK_VCOUNT_W-1:0] vcount;
    logic [15:0]              rgb565;
  } pixel_beat_t;

  // beat after colour space conversion
  typedef struct packed {
    logic                     valid;
    logic                     sof;
    logic [`TRK_HCOUNT_W-1:0] hcount;
    logic [`TRK_VCOUNT_W-1:0] vcount;
    logic [7:0]               cr;
    logic [7:0]               cb;
  } chroma_beat_t;

  // bit 0 is target 0 (cr), bit 1 is target 1 (cb)
  typedef struct packed {
    logic                     valid;
    logic                     sof;
    logic [`TRK_HCOUNT_W-1:0] hcount;
    logic [`TRK_VCOUNT_W-1:0] vcount;
    logic [1:0]               mask;
  } mask_beat_t;

  // upper in 15:8, lower in 7:0, matches the register layout
  typedef struct packed {
    logic [7:0] upper;
    logic [7:0] lower;
  } bounds_t;

  // valid is sticky once a division has landed
  typedef struct packed {
    logic                     valid;
    logic [`TRK_HCOUNT_W-1:0] x;
    logic [`TRK_VCOUNT_W-1:0] y;
  } centroid_t;

  typedef struct packed {
    logic                     valid;
    logic [`TRK_HCOUNT_W-1:0] hcount;
    logic [`TRK_VCOUNT_W-1:0] vcount;
    logic [23:0]              rgb888;
  } video_beat_t;

  typedef enum logic [1:0] {
    IDLE,
    DIVIDE,
    LOAD
  } div_state_e;

  typedef enum logic [`TRK_ADDR_W-1:0] {
    BOUNDS0 = `TRK_REG_BOUNDS0,
    BOUNDS1 = `TRK_REG_BOUNDS1,
    CENTRE0 = `TRK_REG_CENTRE0,
    CENTRE1 = `TRK_REG_CENTRE1
  } reg_addr_e;

endpackage

// ==== chroma_convert.sv ====
`timescale 1ns/1ps
`include "tracker_settings.svh"

module chroma_convert import tracker_pkg::*;
(
  input  logic         clk_camera,
  input  logic         sys_rst_pixel,
  input  pixel_beat_t  beat_i,
  output chroma_beat_t chroma_o
);

  localparam int LAT = `TRK_CHROMA_LAT;

  // rgb565 widened to 8 bits per channel, then to product width
  logic [14:0] r_w, g_w, b_w;
  // stage 1, unsigned coefficient products
  logic [14:0] cr_r_q, cr_g_q, cr_b_q;
  logic [14:0] cb_r_q, cb_g_q, cb_b_q;
  // stage 2, signed weighted sums
  logic signed [16:0] cr_sum_q, cb_sum_q;
  logic signed [16:0] cr_shr, cb_shr;
  // stage 3, offset chroma
  logic [7:0] cr_q, cb_q;
  // side band travelling with the math
  logic [LAT-1:0] vld_q, sof_q;
  logic [`TRK_HCOUNT_W-1:0] hcnt_q [LAT];
  logic [`TRK_VCOUNT_W-1:0] vcnt_q [LAT];

  // low bits zero filled
  assign r_w = {7'b0, beat_i.rgb565[15:11], 3'b000};
  assign g_w = {7'b0, beat_i.rgb565[10:5], 2'b00};
  assign b_w = {7'b0, beat_i.rgb565[4:0], 3'b000};

  // arithmetic shift gives the floor of a negative sum
  assign cr_shr = cr_sum_q >>> 8;
  assign cb_shr = cb_sum_q >>> 8;

  always_ff @(posedge clk_camera)
  begin
    // cr = 112r - 94g - 18b, cb = -38r - 74g + 112b
    cr_r_q <= r_w * 15'd112;
    cr_g_q <= g_w * 15'd94;
    cr_b_q <= b_w * 15'd18;
    cb_r_q <= r_w * 15'd38;
    cb_g_q <= g_w * 15'd74;
    cb_b_q <= b_w * 15'd112;
    cr_sum_q <= $signed({2'b00, cr_r_q}) - $signed({2'b00, cr_g_q})
                - $signed({2'b00, cr_b_q});
    cb_sum_q <= $signed({2'b00, cb_b_q}) - $signed({2'b00, cb_r_q})
                - $signed({2'b00, cb_g_q});
    // +128 recentres, result always within 16..239
    cr_q <= cr_shr[7:0] + 8'd128;
    cb_q <= cb_shr[7:0] + 8'd128;
    hcnt_q[0] <= beat_i.hcount;
    vcnt_q[0] <= beat_i.vcount;
    for (int i = 1; i < LAT; i++)
    begin
      hcnt_q[i] <= hcnt_q[i-1];
      vcnt_q[i] <= vcnt_q[i-1];
    end
  end

  // qualifiers need a clean start
  always_ff @(posedge clk_camera)
  begin
    if (sys_rst_pixel)
    begin
      vld_q <= '0;
      sof_q <= '0;
    end
    else
    begin
      vld_q <= {vld_q[LAT-2:0], beat_i.valid};
      sof_q <= {sof_q[LAT-2:0], beat_i.sof};
    end
  end

  always_comb
  begin
    chroma_o.valid  = vld_q[LAT-1];
    chroma_o.sof    = sof_q[LAT-1];
    chroma_o.hcount = hcnt_q[LAT-1];
    chroma_o.vcount = vcnt_q[LAT-1];
    chroma_o.cr     = cr_q;
    chroma_o.cb     = cb_q;
  end

endmodule

// ==== chroma_threshold.sv ====
`timescale 1ns/1ps
`include "tracker_settings.svh"

module chroma_threshold import tracker_pkg::*;
(
  input  logic         clk_camera,
  input  logic         sys_rst_pixel,
  input  chroma_beat_t chroma_i,
  input  bounds_t      bounds0_i,
  input  bounds_t      bounds1_i,
  output mask_beat_t   mask_o
);

  logic in0, in1;
  logic vld_q, sof_q;
  logic [1:0] mask_q;
  logic [`TRK_HCOUNT_W-1:0] hcnt_q;
  logic [`TRK_VCOUNT_W-1:0] vcnt_q;

  // inclusive windows, target 0 on cr and target 1 on cb
  assign in0 = (chroma_i.cr >= bounds0_i.lower) && (chroma_i.cr <= bounds0_i.upper);
  assign in1 = (chroma_i.cb >= bounds1_i.lower) && (chroma_i.cb <= bounds1_i.upper);

  always_ff @(posedge clk_camera)
  begin
    if (sys_rst_pixel)
    begin
      vld_q <= 1'b0;
      sof_q <= 1'b0;
    end
    else
    begin
      vld_q <= chroma_i.valid;
      sof_q <= chroma_i.sof;
    end
  end

  // mask bits only mean something alongside vld_q
  always_ff @(posedge clk_camera)
  begin
    mask_q <= {in1, in0};
    hcnt_q <= chroma_i.hcount;
    vcnt_q <= chroma_i.vcount;
  end

  always_comb
  begin
    mask_o.valid  = vld_q;
    mask_o.sof    = sof_q;
    mask_o.hcount = hcnt_q;
    mask_o.vcount = vcnt_q;
    mask_o.mask   = mask_q;
  end

endmodule

// ==== centroid_accum.sv ====
`timescale 1ns/1ps
`include "tracker_settings.svh"

module centroid_accum import tracker_pkg::*;
#(
  parameter int DIV_W = `TRK_SUM_W
)
(
  input  logic       clk_camera,
  input  logic       sys_rst_pixel,
  input  mask_beat_t mask_i,
  input  logic       hit_i,
  output centroid_t  centre_o
);

  localparam int CNT_W = $clog2(DIV_W);

  logic close_frame, hit_v, start_div;
  logic [DIV_W-1:0] x_ext, y_ext;
  logic [DIV_W-1:0] sum_x_q, sum_y_q, count_q;
  div_state_e state_q;
  logic [CNT_W-1:0] bit_cnt_q;
  logic [DIV_W-1:0] den_q, rem_x_q, quo_x_q, rem_y_q, quo_y_q;
  logic [2*DIV_W-1:0] step_x, step_y;
  centroid_t centre_q;

  // one restoring step, returns {remainder, quotient}
  // quotient register starts as the dividend and fills from the right
  function automatic logic [2*DIV_W-1:0] div_step(
    input logic [DIV_W-1:0] rem,
    input logic [DIV_W-1:0] quo,
    input logic [DIV_W-1:0] den
  );
    logic [DIV_W+1:0] trial;
    trial = {1'b0, rem, quo[DIV_W-1]} - {2'b00, den};
    if (trial[DIV_W+1])
      div_step = {rem[DIV_W-2:0], quo[DIV_W-1], quo[DIV_W-2:0], 1'b0};
    else
      div_step = {trial[DIV_W-1:0], quo[DIV_W-2:0], 1'b1};
  endfunction

  assign hit_v       = mask_i.valid && hit_i;
  assign close_frame = mask_i.valid && mask_i.sof;
  // empty frames and busy divider both skip the division
  assign start_div   = close_frame && (count_q != '0) && (state_q == IDLE);
  assign x_ext       = DIV_W'(mask_i.hcount);
  assign y_ext       = DIV_W'(mask_i.vcount);
  assign step_x      = div_step(rem_x_q, quo_x_q, den_q);
  assign step_y      = div_step(rem_y_q, quo_y_q, den_q);

  // per-frame sums, the sof beat opens the next frame
  always_ff @(posedge clk_camera)
  begin
    if (sys_rst_pixel)
    begin
      sum_x_q <= '0;
      sum_y_q <= '0;
      count_q <= '0;
    end
    else if (close_frame)
    begin
      sum_x_q <= hit_v ? x_ext : '0;
      sum_y_q <= hit_v ? y_ext : '0;
      count_q <= hit_v ? DIV_W'(1) : '0;
    end
    else if (hit_v)
    begin
      sum_x_q <= sum_x_q + x_ext;
      sum_y_q <= sum_y_q + y_ext;
      count_q <= count_q + 1'b1;
    end
  end

  // divider sequencing and held result
  always_ff @(posedge clk_camera)
  begin
    if (sys_rst_pixel)
    begin
      state_q   <= IDLE;
      bit_cnt_q <= '0;
      centre_q  <= '0;
    end
    else
    begin
      case (state_q)
        IDLE:
          if (start_div)
          begin
            state_q   <= DIVIDE;
            bit_cnt_q <= CNT_W'(DIV_W - 1);
          end
        DIVIDE:
        begin
          if (bit_cnt_q == '0)
            state_q <= LOAD;
          bit_cnt_q <= bit_cnt_q - 1'b1;
        end
        LOAD:
        begin
          centre_q.valid <= 1'b1;
          centre_q.x     <= quo_x_q[`TRK_HCOUNT_W-1:0];
          centre_q.y     <= quo_y_q[`TRK_VCOUNT_W-1:0];
          state_q        <= IDLE;
        end
        default:
          state_q <= IDLE;
      endcase
    end
  end

  // x and y share the divisor, so both finish together
  always_ff @(posedge clk_camera)
  begin
    if (start_div)
    begin
      den_q   <= count_q;
      quo_x_q <= sum_x_q;
      quo_y_q <= sum_y_q;
      rem_x_q <= '0;
      rem_y_q <= '0;
    end
    else if (state_q == DIVIDE)
    begin
      {rem_x_q, quo_x_q} <= step_x;
      {rem_y_q, quo_y_q} <= step_y;
    end
  end

  assign centre_o = centre_q;

  // frames shorter than the divider run lose their totals
  a_no_overlap: assert property (@(posedge clk_camera) disable iff (sys_rst_pixel)
    (close_frame && (count_q != '0)) |-> (state_q == IDLE))
    else $error("centroid_accum: frame closed while divider busy");

  // a single load lands a fixed time after each start
  a_one_load: assert property (@(posedge clk_camera) disable iff (sys_rst_pixel)
    start_div |-> ##(DIV_W + 1) (state_q == LOAD) ##1 (state_q != LOAD))
    else $error("centroid_accum: load missing or repeated");

endmodule

// ==== tracker_regs.sv ====
`timescale 1ns/1ps
`include "tracker_settings.svh"

module tracker_regs import tracker_pkg::*;
(
  input  logic                   clk_camera,
  input  logic                   sys_rst_pixel,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`TRK_ADDR_W-1:0] paddr_i,
  input  logic [`TRK_DATA_W-1:0] pwdata_i,
  output logic [`TRK_DATA_W-1:0] prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  input  centroid_t              centre0_i,
  input  centroid_t              centre1_i,
  output bounds_t                bounds0_o,
  output bounds_t                bounds1_o
);

  reg_addr_e addr;
  logic access, bad_access, wr_en;
  logic [`TRK_DATA_W-1:0] rdata;
  bounds_t bounds0_q, bounds1_q;

  // x in 10:0, y in 25:16, sticky valid in 31
  function automatic logic [`TRK_DATA_W-1:0] centre_word(input centroid_t c);
    centre_word = {c.valid, 5'b0, c.y, 5'b0, c.x};
  endfunction

  assign addr   = reg_addr_e'(paddr_i);
  assign access = psel_i && penable_i;

  // read mux and error decode
  always_comb
  begin
    rdata      = '0;
    bad_access = 1'b0;
    case (addr)
      BOUNDS0: rdata = `TRK_DATA_W'(bounds0_q);
      BOUNDS1: rdata = `TRK_DATA_W'(bounds1_q);
      CENTRE0:
      begin
        rdata      = centre_word(centre0_i);
        bad_access = pwrite_i;
      end
      CENTRE1:
      begin
        rdata      = centre_word(centre1_i);
        bad_access = pwrite_i;
      end
      default: bad_access = 1'b1;
    endcase
  end

  // rejected writes never reach the bounds
  assign wr_en = access && pwrite_i && !bad_access;

  always_ff @(posedge clk_camera)
  begin
    if (sys_rst_pixel)
    begin
      bounds0_q <= '{upper: `TRK_UPPER_RST, lower: `TRK_LOWER_RST};
      bounds1_q <= '{upper: `TRK_UPPER_RST, lower: `TRK_LOWER_RST};
    end
    else if (wr_en && (addr == BOUNDS0))
      bounds0_q <= bounds_t'(pwdata_i[15:0]);
    else if (wr_en && (addr == BOUNDS1))
      bounds1_q <= bounds_t'(pwdata_i[15:0]);
  end

  // no wait states
  assign pready_o  = 1'b1;
  assign pslverr_o = access && bad_access;
  // bus stays quiet outside read access
  assign prdata_o  = (access && !pwrite_i) ? rdata : '0;
  assign bounds0_o = bounds0_q;
  assign bounds1_o = bounds1_q;

  // an error belongs to the access phase that follows a setup phase
  a_err_phase: assert property (@(posedge clk_camera) disable iff (sys_rst_pixel)
    pslverr_o |-> (penable_i && $past(psel_i && !penable_i)))
    else $error("tracker_regs: pslverr outside an access phase");

endmodule

// ==== crosshair_overlay.sv ====
`timescale 1ns/1ps
`include "tracker_settings.svh"

module crosshair_overlay import tracker_pkg::*;
(
  input  logic        clk_camera,
  input  logic        sys_rst_pixel,
  input  pixel_beat_t beat_i,
  input  centroid_t   centre0_i,
  input  centroid_t   centre1_i,
  output video_beat_t pix_o
);

  // same depth as convert plus threshold
  localparam int ALIGN = `TRK_CHROMA_LAT + `TRK_THRESH_LAT;

  logic [ALIGN-1:0] vld_q;
  pixel_beat_t dly_q [ALIGN];
  pixel_beat_t aligned;
  logic on_line;
  logic out_vld_q;
  logic [`TRK_HCOUNT_W-1:0] out_h_q;
  logic [`TRK_VCOUNT_W-1:0] out_v_q;
  logic [23:0] out_rgb_q;

  assign aligned = dly_q[ALIGN-1];
  // centres drawn even before their first division, like the camera build
  assign on_line = (aligned.hcount == centre0_i.x) || (aligned.hcount == centre1_i.x)
                || (aligned.vcount == centre0_i.y) || (aligned.vcount == centre1_i.y);

  always_ff @(posedge clk_camera)
  begin
    if (sys_rst_pixel)
    begin
      vld_q     <= '0;
      out_vld_q <= 1'b0;
    end
    else
    begin
      vld_q     <= {vld_q[ALIGN-2:0], beat_i.valid};
      out_vld_q <= vld_q[ALIGN-1];
    end
  end

  always_ff @(posedge clk_camera)
  begin
    dly_q[0] <= beat_i;
    for (int i = 1; i < ALIGN; i++)
      dly_q[i] <= dly_q[i-1];
    out_h_q <= aligned.hcount;
    out_v_q <= aligned.vcount;
    // white line, else the expanded camera colour
    if (on_line)
      out_rgb_q <= 24'hFF_FF_FF;
    else
      out_rgb_q <= {aligned.rgb565[15:11], 3'b000, aligned.rgb565[10:5], 2'b00,
                    aligned.rgb565[4:0], 3'b000};
  end

  always_comb
  begin
    pix_o.valid  = out_vld_q;
    pix_o.hcount = out_h_q;
    pix_o.vcount = out_v_q;
    pix_o.rgb888 = out_rgb_q;
  end

endmodule

// ==== color_tracker_top.sv ====
`timescale 1ns/1ps
`include "tracker_settings.svh"

module color_tracker_top import tracker_pkg::*;
(
  input  logic                   clk_camera,
  input  logic                   sys_rst_pixel,
  input  pixel_beat_t            pix_i,
  output video_beat_t            pix_o,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`TRK_ADDR_W-1:0] paddr_i,
  input  logic [`TRK_DATA_W-1:0] pwdata_i,
  output logic [`TRK_DATA_W-1:0] prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o
);

  chroma_beat_t chroma;
  mask_beat_t   mask;
  bounds_t      bounds0, bounds1;
  centroid_t    centre0, centre1;

  chroma_convert u_convert (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .beat_i        (pix_i),
    .chroma_o      (chroma)
  );

  chroma_threshold u_threshold (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .chroma_i      (chroma),
    .bounds0_i     (bounds0),
    .bounds1_i     (bounds1),
    .mask_o        (mask)
  );

  // target 0 tracks the cr mask
  centroid_accum u_centroid0 (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .mask_i        (mask),
    .hit_i         (mask.mask[0]),
    .centre_o      (centre0)
  );

  // target 1 tracks the cb mask
  centroid_accum u_centroid1 (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .mask_i        (mask),
    .hit_i         (mask.mask[1]),
    .centre_o      (centre1)
  );

  tracker_regs u_regs (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .centre0_i     (centre0),
    .centre1_i     (centre1),
    .bounds0_o     (bounds0),
    .bounds1_o     (bounds1)
  );

  crosshair_overlay u_overlay (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .beat_i        (pix_i),
    .centre0_i     (centre0),
    .centre1_i     (centre1),
    .pix_o         (pix_o)
  );

endmodule

// ==== tb_color_tracker.sv ====
`timescale 1ns/1ps
`include "tracker_settings.svh"

module tb_color_tracker import tracker_pkg::*;
();

  // expected output beat; while a centre moves either colour is accepted
  typedef struct packed {
    logic                     valid;
    logic                     loose;
    logic [`TRK_HCOUNT_W-1:0] hcount;
    logic [`TRK_VCOUNT_W-1:0] vcount;
    logic [23:0]              rgb_new;
    logic [23:0]              rgb_old;
  } model_beat_t;

  localparam int FRAME_W = 16;
  localparam int FRAME_H = 8;
  // centre lands about 35 beats into the frame after the close
  localparam int SETTLE_BEATS = 48;
  // 7 frames of 128 beats, ~25 register accesses, polls and idle gaps stay near 1000
  localparam int TIMEOUT_CYC = 6000;
  localparam logic [15:0] RED  = 16'hF800;
  localparam logic [15:0] BLUE = 16'h001F;

  logic clk_camera;
  logic sys_rst_pixel;
  pixel_beat_t pix_i;
  video_beat_t pix_o;
  logic psel_i, penable_i, pwrite_i;
  logic [`TRK_ADDR_W-1:0] paddr_i;
  logic [`TRK_DATA_W-1:0] pwdata_i, prdata_o;
  logic pready_o, pslverr_o;

  model_beat_t mdl_in, exp_beat;
  model_beat_t mdl_q [5];
  logic rd_chk, err_exp;
  logic [31:0] rd_exp;
  int pix_errs = 0;
  int reg_errs = 0;
  int other_errs = 0;
  int cycles = 0;
  int unsigned seed_val;
  // per-target model: current and previous centre, open sums, window
  int cx [2] = '{0, 0};
  int cy [2] = '{0, 0};
  int ox [2] = '{0, 0};
  int oy [2] = '{0, 0};
  int sx [2] = '{0, 0};
  int sy [2] = '{0, 0};
  int cnt [2] = '{0, 0};
  logic cvalid [2] = '{1'b0, 1'b0};
  logic [7:0] lo [2] = '{`TRK_LOWER_RST, `TRK_LOWER_RST};
  logic [7:0] hi [2] = '{`TRK_UPPER_RST, `TRK_UPPER_RST};

  color_tracker_top dut_i (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .pix_i         (pix_i),
    .pix_o         (pix_o),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o)
  );

  initial
  begin
    clk_camera = 1'b0;
    forever #10 clk_camera = ~clk_camera;
  end

  // five-deep model pipe, same depth as the overlay path
  always @(posedge clk_camera)
  begin
    if (sys_rst_pixel)
    begin
      for (int i = 0; i < 5; i++)
        mdl_q[i] <= '0;
    end
    else
    begin
      mdl_q[0] <= mdl_in;
      for (int i = 1; i < 5; i++)
        mdl_q[i] <= mdl_q[i-1];
    end
  end

  assign exp_beat = mdl_q[4];

  always @(posedge clk_camera)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYC)
    begin
      $display("timeout: run still going after %0d cycles", TIMEOUT_CYC);
      $display("errors: pixel %0d, register %0d, other %0d", pix_errs, reg_errs, other_errs);
      $display("Done: errors found");
      $finish;
    end
  end

  a_reset_quiet: assert property (@(posedge clk_camera) $fell(sys_rst_pixel) |-> !pix_o.valid)
    else
    begin
      pix_errs++;
      $display("** Error at %0t: pix_o.valid = %b right after reset, expected 0", $time,
               $sampled(pix_o.valid));
    end

  a_pix_valid: assert property (@(posedge clk_camera) disable iff (sys_rst_pixel)
    pix_o.valid == exp_beat.valid)
    else
    begin
      pix_errs++;
      $display("** Error at %0t: pix_o.valid = %b, expected %b", $time,
               $sampled(pix_o.valid), $sampled(exp_beat.valid));
    end

  a_pix_coord: assert property (@(posedge clk_camera) disable iff (sys_rst_pixel)
    exp_beat.valid |-> (pix_o.hcount == exp_beat.hcount && pix_o.vcount == exp_beat.vcount))
    else
    begin
      pix_errs++;
      $display("** Error at %0t: pix_o.hcount/vcount = %0d/%0d, expected %0d/%0d", $time,
               $sampled(pix_o.hcount), $sampled(pix_o.vcount),
               $sampled(exp_beat.hcount), $sampled(exp_beat.vcount));
    end

  a_pix_rgb: assert property (@(posedge clk_camera) disable iff (sys_rst_pixel)
    exp_beat.valid |-> (pix_o.rgb888 == exp_beat.rgb_new
                        || (exp_beat.loose && pix_o.rgb888 == exp_beat.rgb_old)))
    else
    begin
      pix_errs++;
      $display("** Error at %0t: pix_o.rgb888 = %h, expected %h", $time,
               $sampled(pix_o.rgb888), $sampled(exp_beat.rgb_new));
    end

  a_rd_data: assert property (@(posedge clk_camera) disable iff (sys_rst_pixel)
    (psel_i && penable_i && !pwrite_i && rd_chk) |-> (prdata_o == rd_exp))
    else
    begin
      reg_errs++;
      $display("** Error at %0t: prdata_o = %h, expected %h (paddr %h)", $time,
               $sampled(prdata_o), $sampled(rd_exp), $sampled(paddr_i));
    end

  // also keeps the error low outside access phases
  a_slverr: assert property (@(posedge clk_camera) disable iff (sys_rst_pixel)
    pslverr_o == (psel_i && penable_i && err_exp))
    else
    begin
      reg_errs++;
      $display("** Error at %0t: pslverr_o = %b, expected %b", $time,
               $sampled(pslverr_o), $sampled(psel_i && penable_i && err_exp));
    end

  a_ready: assert property (@(posedge clk_camera) disable iff (sys_rst_pixel)
    (psel_i && penable_i) |-> pready_o)
    else
    begin
      reg_errs++;
      $display("** Error at %0t: pready_o = %b, expected 1", $time, $sampled(pready_o));
    end

  function automatic logic [23:0] expand565(input logic [15:0] c);
    return {c[15:11], 3'b000, c[10:5], 2'b00, c[4:0], 3'b000};
  endfunction

  // white on any row or column of either centre
  function automatic logic [23:0] paint(input logic [15:0] c, input int h, input int v,
                                        input int x0, input int y0, input int x1, input int y1);
    if (h == x0 || h == x1 || v == y0 || v == y1)
      return 24'hFF_FF_FF;
    return expand565(c);
  endfunction

  function automatic logic in_window(input logic [7:0] val, input int t);
    return (val >= lo[t]) && (val <= hi[t]);
  endfunction

  // red is cr EC / cb 5B, blue is cr 6E / cb EC, grey sits near 80
  function automatic logic [1:0] colour_hits(input logic [15:0] c);
    if (c == RED)
      return {in_window(8'h5B, 1), in_window(8'hEC, 0)};
    if (c == BLUE)
      return {in_window(8'hEC, 1), in_window(8'h6E, 0)};
    return 2'b00;
  endfunction

  // channels at most 28 in 8-bit terms
  function automatic logic [15:0] dark_grey();
    logic [31:0] r;
    r = $urandom();
    return {3'b000, r[1:0], 3'b000, r[4:2], 3'b000, r[6:5]};
  endfunction

  function automatic logic [31:0] centre_reg_value(input int t);
    return {cvalid[t], 5'b0, cy[t][9:0], 5'b0, cx[t][10:0]};
  endfunction

  // sof closes the open frame in the model as well
  task automatic close_model_frame(output logic moved);
    moved = 1'b0;
    for (int t = 0; t < 2; t++)
    begin
      ox[t] = cx[t];
      oy[t] = cy[t];
      if (cnt[t] != 0)
      begin
        cx[t] = sx[t] / cnt[t];
        cy[t] = sy[t] / cnt[t];
        cvalid[t] = 1'b1;
        moved = 1'b1;
      end
      sx[t] = 0;
      sy[t] = 0;
      cnt[t] = 0;
    end
  endtask

  task automatic drive_beat(input logic sof, input int h, input int v, input logic [15:0] c,
                            input logic loose);
    logic [1:0] hits;
    hits = colour_hits(c);
    for (int t = 0; t < 2; t++)
    begin
      if (hits[t])
      begin
        sx[t] += h;
        sy[t] += v;
        cnt[t]++;
      end
    end
    @(posedge clk_camera);
    #2;
    pix_i.valid = 1'b1;
    pix_i.sof = sof;
    pix_i.hcount = h[`TRK_HCOUNT_W-1:0];
    pix_i.vcount = v[`TRK_VCOUNT_W-1:0];
    pix_i.rgb565 = c;
    mdl_in.valid = 1'b1;
    mdl_in.loose = loose;
    mdl_in.hcount = h[`TRK_HCOUNT_W-1:0];
    mdl_in.vcount = v[`TRK_VCOUNT_W-1:0];
    mdl_in.rgb_new = paint(c, h, v, cx[0], cy[0], cx[1], cy[1]);
    mdl_in.rgb_old = paint(c, h, v, ox[0], oy[0], ox[1], oy[1]);
  endtask

  // block of colour c over x0..x1, y0..y1 on grey; empty range gives a plain frame
  task automatic drive_frame(input logic [15:0] c, input int x0, input int x1,
                             input int y0, input int y1);
    logic moved;
    logic [15:0] col;
    close_model_frame(moved);
    for (int v = 0; v < FRAME_H; v++)
    begin
      for (int h = 0; h < FRAME_W; h++)
      begin
        if (h >= x0 && h <= x1 && v >= y0 && v <= y1)
          col = c;
        else
          col = dark_grey();
        drive_beat(h == 0 && v == 0, h, v, col, moved && (v * FRAME_W + h < SETTLE_BEATS));
      end
    end
  endtask

  task automatic idle_beats(input int n);
    repeat (n)
    begin
      @(posedge clk_camera);
      #2;
      pix_i = '0;
      mdl_in = '0;
    end
  endtask

  // setup then access, no wait states
  task automatic apb_xfer(input logic wr, input logic [`TRK_ADDR_W-1:0] addr,
                          input logic [31:0] wdata, input logic chk, input logic [31:0] exp,
                          input logic exp_err, output logic [31:0] rdata);
    @(posedge clk_camera);
    #2;
    psel_i = 1'b1;
    penable_i = 1'b0;
    pwrite_i = wr;
    paddr_i = addr;
    pwdata_i = wdata;
    rd_chk = chk;
    rd_exp = exp;
    err_exp = exp_err;
    @(posedge clk_camera);
    #2;
    penable_i = 1'b1;
    // read data holds steady mid access phase
    @(negedge clk_camera);
    rdata = prdata_o;
    @(posedge clk_camera);
    #2;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    rd_chk = 1'b0;
    err_exp = 1'b0;
  endtask

  task automatic reg_write(input logic [`TRK_ADDR_W-1:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] unused;
    apb_xfer(1'b1, addr, data, 1'b0, '0, exp_err, unused);
    if (!exp_err && addr == BOUNDS0)
    begin
      lo[0] = data[7:0];
      hi[0] = data[15:8];
    end
    if (!exp_err && addr == BOUNDS1)
    begin
      lo[1] = data[7:0];
      hi[1] = data[15:8];
    end
  endtask

  task automatic reg_read(input logic [`TRK_ADDR_W-1:0] addr, input logic [31:0] exp,
                          input logic exp_err);
    logic [31:0] unused;
    apb_xfer(1'b0, addr, '0, 1'b1, exp, exp_err, unused);
  endtask

  task automatic wait_centre_valid(input logic [`TRK_ADDR_W-1:0] addr);
    logic [31:0] rdata;
    int tries;
    rdata = '0;
    tries = 0;
    while (!rdata[31] && tries < 64)
    begin
      apb_xfer(1'b0, addr, '0, 1'b0, '0, 1'b0, rdata);
      tries++;
    end
    if (!rdata[31])
    begin
      other_errs++;
      $display("centre register at offset %h never reported a valid result", addr);
    end
  endtask

  initial
  begin
    seed_val = $urandom(42);
    sys_rst_pixel = 1'b1;
    pix_i = '0;
    mdl_in = '0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    rd_chk = 1'b0;
    rd_exp = '0;
    err_exp = 1'b0;
    repeat (2) @(posedge clk_camera);
    #2;
    sys_rst_pixel = 1'b0;
    idle_beats(3);

    // reset contents
    reg_read(CENTRE0, 32'h0, 1'b0);
    reg_read(CENTRE1, 32'h0, 1'b0);
    reg_read(BOUNDS0, 32'h0000_F0A0, 1'b0);
    reg_read(BOUNDS1, 32'h0000_F0A0, 1'b0);

    // readback, then rejected accesses
    reg_write(BOUNDS1, 32'h0000_C050, 1'b0);
    reg_read(BOUNDS1, 32'h0000_C050, 1'b0);
    reg_write(4'h2, 32'h0000_1234, 1'b1);
    reg_write(CENTRE0, 32'hFFFF_FFFF, 1'b1);
    reg_read(4'h6, 32'h0, 1'b1);
    reg_read(CENTRE0, 32'h0, 1'b0);
    reg_read(BOUNDS0, 32'h0000_F0A0, 1'b0);
    reg_read(BOUNDS1, 32'h0000_C050, 1'b0);
    reg_write(BOUNDS1, 32'h0000_F0A0, 1'b0);

    // red block, mean x 5.5 and y 2, closed by a plain frame
    drive_frame(RED, 3, 8, 1, 3);
    drive_frame(RED, 1, 0, 1, 0);
    idle_beats(8);
    wait_centre_valid(CENTRE0);
    reg_read(CENTRE0, centre_reg_value(0), 1'b0);
    reg_read(CENTRE1, centre_reg_value(1), 1'b0);

    // blue block, then a frame drawing both crosshairs, then an empty close
    drive_frame(BLUE, 10, 13, 4, 6);
    drive_frame(BLUE, 1, 0, 1, 0);
    drive_frame(BLUE, 1, 0, 1, 0);
    idle_beats(8);
    wait_centre_valid(CENTRE1);
    reg_read(CENTRE0, centre_reg_value(0), 1'b0);
    reg_read(CENTRE1, centre_reg_value(1), 1'b0);

    // upper bound E0 shuts out red, centre 0 must hold
    reg_write(BOUNDS0, 32'h0000_E0A0, 1'b0);
    reg_read(BOUNDS0, 32'h0000_E0A0, 1'b0);
    drive_frame(RED, 6, 12, 5, 7);
    drive_frame(RED, 1, 0, 1, 0);
    idle_beats(8);
    reg_read(CENTRE0, centre_reg_value(0), 1'b0);
    reg_read(CENTRE1, centre_reg_value(1), 1'b0);
    idle_beats(8);

    $display("errors: pixel %0d, register %0d, other %0d", pix_errs, reg_errs, other_errs);
    if (pix_errs + reg_errs + other_errs == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+.
tracker_pkg.sv
chroma_convert.sv
chroma_threshold.sv
centroid_accum.sv
tracker_regs.sv
crosshair_overlay.sv
color_tracker_top.sv
tb_color_tracker.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the colour tracker testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_color_tracker -f project.f -o tb_color_tracker \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_color_tracker > sim.log 2>&1 || echo "simulator exited with an error status"
cat sim.log

# result comes from the log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "FAIL: run ended without a result line"; exit 1; }
echo "PASS"
exit 0
